// ==== design/prf_pkg.sv ====
/* Physical register file definitions */
package prf_pkg;

    // Register storage sizing
    localparam int DATA_W   = 32;
    localparam int N_PREG   = 64;
    localparam int PREG_W   = $clog2(N_PREG);
    localparam int ROB_ID_W = 3;

    // Two allocations per cycle from the dispatch stage
    localparam int N_DISP = 2;

    // Writeback channels
    // 0 is ALU, 1 is multiplier, 2 is load/store
    localparam int N_WB = 3;

    // Read ports, each with an rs1 and an rs2 source
    localparam int N_READ = 4;

    // Physical register index
    typedef logic [PREG_W-1:0] preg_t;

    // Register value
    typedef logic [DATA_W-1:0] data_t;

    // Reorder buffer tag
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // One entry of the register file
    // dependency is set at dispatch, cleared at writeback
    typedef struct packed {
        data_t   value;
        logic    dependency;
        rob_id_t rob_id;
    } prf_entry_t;

endpackage

// ==== design/prf_storage.sv ====
/* Register file entry storage */
module prf_storage (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,

    // Dispatch allocation
    input  logic                disp_en     [prf_pkg::N_DISP],
    input  prf_pkg::preg_t      disp_rd     [prf_pkg::N_DISP],
    input  prf_pkg::rob_id_t    disp_rob_id [prf_pkg::N_DISP],

    // Writeback channels
    input  logic                wb_valid    [prf_pkg::N_WB],
    input  prf_pkg::preg_t      wb_rd       [prf_pkg::N_WB],
    input  prf_pkg::data_t      wb_value    [prf_pkg::N_WB],
    input  prf_pkg::rob_id_t    wb_rob_id   [prf_pkg::N_WB],

    // Whole array, to the read bypass
    output prf_pkg::prf_entry_t entries     [prf_pkg::N_PREG]
);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < prf_pkg::N_PREG; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            // Allocation marks the entry as waiting on its ROB tag
            for (int d = 0; d < prf_pkg::N_DISP; d++) begin
                if (disp_en[d]) begin
                    entries[disp_rd[d]].dependency <= 1'b1;
                    entries[disp_rd[d]].rob_id     <= disp_rob_id[d];
                end
            end

            // Result arrives, dependency resolved
            // rob_id is left as recorded by dispatch
            for (int c = 0; c < prf_pkg::N_WB; c++) begin
                if (wb_valid[c]) begin
                    entries[wb_rd[c]].value      <= wb_value[c];
                    entries[wb_rd[c]].dependency <= 1'b0;
                end
            end
        end
    end

    // Update conflicts
    // Register renaming keeps these targets disjoint within one cycle
    for (genvar a = 0; a < prf_pkg::N_WB; a++) begin : g_wb_chk
        for (genvar b = a + 1; b < prf_pkg::N_WB; b++) begin : g_wb_pair
            a_wb_unique : assert property (
                @(posedge clk) disable iff (rst)
                (we && wb_valid[a] && wb_valid[b]) |-> (wb_rd[a] != wb_rd[b])
            ) else $error("writeback channels %0d and %0d share register %0d",
                          a, b, wb_rd[a]);
        end
    end

    for (genvar a = 0; a < prf_pkg::N_DISP; a++) begin : g_disp_chk
        for (genvar b = a + 1; b < prf_pkg::N_DISP; b++) begin : g_disp_pair
            a_disp_unique : assert property (
                @(posedge clk) disable iff (rst)
                (we && disp_en[a] && disp_en[b]) |-> (disp_rd[a] != disp_rd[b])
            ) else $error("dispatch ports %0d and %0d share register %0d",
                          a, b, disp_rd[a]);
        end
    end

    // A register being allocated cannot also be receiving its result
    for (genvar d = 0; d < prf_pkg::N_DISP; d++) begin : g_cross_chk
        for (genvar c = 0; c < prf_pkg::N_WB; c++) begin : g_cross_pair
            a_disp_wb_unique : assert property (
                @(posedge clk) disable iff (rst)
                (we && disp_en[d] && wb_valid[c]) |-> (disp_rd[d] != wb_rd[c])
            ) else $error("dispatch port %0d and writeback channel %0d hit register %0d",
                          d, c, disp_rd[d]);
        end
    end

endmodule

// ==== design/cdb_bypass.sv ====
/* Read port writeback bypass */
module cdb_bypass (
    // Source addresses
    input  prf_pkg::preg_t      rs1,
    input  prf_pkg::preg_t      rs2,

    // Stored entries
    input  prf_pkg::prf_entry_t entries   [prf_pkg::N_PREG],

    // Writeback channels, same cycle
    input  logic                wb_valid  [prf_pkg::N_WB],
    input  prf_pkg::preg_t      wb_rd     [prf_pkg::N_WB],
    input  prf_pkg::data_t      wb_value  [prf_pkg::N_WB],
    input  prf_pkg::rob_id_t    wb_rob_id [prf_pkg::N_WB],

    output prf_pkg::data_t      rs1_value,
    output logic                rs1_dep,
    output prf_pkg::rob_id_t    rs1_rob_id,
    output prf_pkg::data_t      rs2_value,
    output logic                rs2_dep,
    output prf_pkg::rob_id_t    rs2_rob_id
);

    // Index 0 is rs1, index 1 is rs2
    prf_pkg::preg_t           src    [2];
    prf_pkg::prf_entry_t      result [2];
    logic [prf_pkg::N_WB-1:0] hit    [2];

    assign src[0] = rs1;
    assign src[1] = rs2;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            // Stored entry unless a writeback targets this source
            result[s] = entries[src[s]];
            for (int c = 0; c < prf_pkg::N_WB; c++) begin
                hit[s][c] = wb_valid[c] && (wb_rd[c] == src[s]);
                if (hit[s][c]) begin
                    result[s].value      = wb_value[c];
                    result[s].dependency = 1'b0;
                    result[s].rob_id     = wb_rob_id[c];
                end
            end
        end
    end

    assign rs1_value  = result[0].value;
    assign rs1_dep    = result[0].dependency;
    assign rs1_rob_id = result[0].rob_id;
    assign rs2_value  = result[1].value;
    assign rs2_dep    = result[1].dependency;
    assign rs2_rob_id = result[1].rob_id;

    // Channel order above only matters if two writebacks collide
    always_comb begin
        a_single_hit : assert final ($onehot0(hit[0]) && $onehot0(hit[1]))
            else $error("more than one writeback matches rs1 %0d or rs2 %0d", rs1, rs2);
    end

endmodule

// ==== design/phys_reg_file.sv ====
/* Physical register file top */
module phys_reg_file (
    input  logic             clk,
    input  logic             rst,

    // Global update enable, low stalls all updates
    input  logic             we,

    // Dispatch allocation
    input  logic             disp_en     [prf_pkg::N_DISP],
    input  prf_pkg::preg_t   disp_rd     [prf_pkg::N_DISP],
    input  prf_pkg::rob_id_t disp_rob_id [prf_pkg::N_DISP],

    // Writeback from ALU, multiplier and load/store
    input  logic             wb_valid    [prf_pkg::N_WB],
    input  prf_pkg::preg_t   wb_rd       [prf_pkg::N_WB],
    input  prf_pkg::data_t   wb_value    [prf_pkg::N_WB],
    input  prf_pkg::rob_id_t wb_rob_id   [prf_pkg::N_WB],

    // Read ports
    input  prf_pkg::preg_t   rs1         [prf_pkg::N_READ],
    input  prf_pkg::preg_t   rs2         [prf_pkg::N_READ],

    output prf_pkg::data_t   rs1_value   [prf_pkg::N_READ],
    output logic             rs1_dep     [prf_pkg::N_READ],
    output prf_pkg::rob_id_t rs1_rob_id  [prf_pkg::N_READ],
    output prf_pkg::data_t   rs2_value   [prf_pkg::N_READ],
    output logic             rs2_dep     [prf_pkg::N_READ],
    output prf_pkg::rob_id_t rs2_rob_id  [prf_pkg::N_READ]
);

    prf_pkg::prf_entry_t entries [prf_pkg::N_PREG];

    prf_storage i_prf_storage (
        .clk         (clk),
        .rst         (rst),
        .we          (we),
        .disp_en     (disp_en),
        .disp_rd     (disp_rd),
        .disp_rob_id (disp_rob_id),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .wb_rob_id   (wb_rob_id),
        .entries     (entries)
    );

    // One bypass per read port, all sharing the writeback channels
    for (genvar p = 0; p < prf_pkg::N_READ; p++) begin : g_read
        cdb_bypass i_cdb_bypass (
            .rs1        (rs1[p]),
            .rs2        (rs2[p]),
            .entries    (entries),
            .wb_valid   (wb_valid),
            .wb_rd      (wb_rd),
            .wb_value   (wb_value),
            .wb_rob_id  (wb_rob_id),
            .rs1_value  (rs1_value[p]),
            .rs1_dep    (rs1_dep[p]),
            .rs1_rob_id (rs1_rob_id[p]),
            .rs2_value  (rs2_value[p]),
            .rs2_dep    (rs2_dep[p]),
            .rs2_rob_id (rs2_rob_id[p])
        );
    end

endmodule

// ==== tests/prf_model.svh ====
/* Register file reference model */
`ifndef PRF_MODEL_SVH
`define PRF_MODEL_SVH

// Expected contents of every physical register
prf_pkg::prf_entry_t model [prf_pkg::N_PREG];

// Applied at each rising edge, from the inputs held since the falling edge
task automatic update_model();
    if (rst) begin
        foreach (model[i]) begin
            model[i] = '0;
        end
    end else if (we) begin
        // Allocation sets the dependency and records the tag
        for (int d = 0; d < prf_pkg::N_DISP; d++) begin
            if (disp_en[d]) begin
                model[disp_rd[d]].dependency = 1'b1;
                model[disp_rd[d]].rob_id     = disp_rob_id[d];
            end
        end
        // Result stored, tag from dispatch stays
        for (int c = 0; c < prf_pkg::N_WB; c++) begin
            if (wb_valid[c]) begin
                model[wb_rd[c]].value      = wb_value[c];
                model[wb_rd[c]].dependency = 1'b0;
            end
        end
    end
endtask

// What one source should read right now
function automatic prf_pkg::prf_entry_t expected_read(input prf_pkg::preg_t src);
    prf_pkg::prf_entry_t e;
    e = model[src];
    // A writeback to this register wins, even with we low
    for (int c = 0; c < prf_pkg::N_WB; c++) begin
        if (wb_valid[c] && wb_rd[c] == src) begin
            e.value      = wb_value[c];
            e.dependency = 1'b0;
            e.rob_id     = wb_rob_id[c];
        end
    end
    return e;
endfunction

`endif

// ==== tests/tb_phys_reg_file.sv ====
/* Physical register file testbench */
module tb_phys_reg_file;

    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = 3000;

    logic             clk;
    logic             rst;
    logic             we;
    logic             disp_en     [prf_pkg::N_DISP];
    prf_pkg::preg_t   disp_rd     [prf_pkg::N_DISP];
    prf_pkg::rob_id_t disp_rob_id [prf_pkg::N_DISP];
    logic             wb_valid    [prf_pkg::N_WB];
    prf_pkg::preg_t   wb_rd       [prf_pkg::N_WB];
    prf_pkg::data_t   wb_value    [prf_pkg::N_WB];
    prf_pkg::rob_id_t wb_rob_id   [prf_pkg::N_WB];
    prf_pkg::preg_t   rs1         [prf_pkg::N_READ];
    prf_pkg::preg_t   rs2         [prf_pkg::N_READ];
    prf_pkg::data_t   rs1_value   [prf_pkg::N_READ];
    logic             rs1_dep     [prf_pkg::N_READ];
    prf_pkg::rob_id_t rs1_rob_id  [prf_pkg::N_READ];
    prf_pkg::data_t   rs2_value   [prf_pkg::N_READ];
    logic             rs2_dep     [prf_pkg::N_READ];
    prf_pkg::rob_id_t rs2_rob_id  [prf_pkg::N_READ];

    integer seed = 32'hb135_1ff7;
    int     cycles = 0;

    `include "prf_model.svh"

    phys_reg_file i_phys_reg_file (
        .clk         (clk),
        .rst         (rst),
        .we          (we),
        .disp_en     (disp_en),
        .disp_rd     (disp_rd),
        .disp_rob_id (disp_rob_id),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .wb_rob_id   (wb_rob_id),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_value   (rs1_value),
        .rs1_dep     (rs1_dep),
        .rs1_rob_id  (rs1_rob_id),
        .rs2_value   (rs2_value),
        .rs2_dep     (rs2_dep),
        .rs2_rob_id  (rs2_rob_id)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        update_model();
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort($sformatf("Run did not finish within %0d clock cycles", MAX_CYCLES));
        end
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Strobes off, we high; addresses and payloads keep their values
    task automatic idle_inputs();
        we = 1'b1;
        foreach (disp_en[d]) begin
            disp_en[d] = 1'b0;
        end
        foreach (wb_valid[c]) begin
            wb_valid[c] = 1'b0;
        end
    endtask

    task automatic clear_inputs();
        idle_inputs();
        foreach (disp_rd[d]) begin
            disp_rd[d]     = '0;
            disp_rob_id[d] = '0;
        end
        foreach (wb_rd[c]) begin
            wb_rd[c]     = '0;
            wb_value[c]  = '0;
            wb_rob_id[c] = '0;
        end
        foreach (rs1[p]) begin
            rs1[p] = '0;
            rs2[p] = '0;
        end
    endtask

    // Directed check against literal values
    task automatic expect_read(input int p, input bit second, input prf_pkg::data_t value,
                               input logic dep, input prf_pkg::rob_id_t rob_id);
        prf_pkg::data_t   got_value;
        logic             got_dep;
        prf_pkg::rob_id_t got_rob_id;
        got_value  = second ? rs2_value[p] : rs1_value[p];
        got_dep    = second ? rs2_dep[p] : rs1_dep[p];
        got_rob_id = second ? rs2_rob_id[p] : rs1_rob_id[p];
        assert (got_value === value && got_dep === dep && got_rob_id === rob_id)
            else abort($sformatf("error at %0t: port %0d rs%0d got %h/%b/%0d, expected %h/%b/%0d",
                                 $time, p, second ? 2 : 1, got_value, got_dep, got_rob_id,
                                 value, dep, rob_id));
    endtask

    task automatic compare_source(input int p, input bit second);
        prf_pkg::prf_entry_t exp;
        exp = expected_read(second ? rs2[p] : rs1[p]);
        expect_read(p, second, exp.value, exp.dependency, exp.rob_id);
    endtask

    // Every source checked each cycle, midway between falling and rising edge
    initial begin
        forever begin
            @(negedge clk);
            #10;
            if (!rst) begin
                for (int p = 0; p < prf_pkg::N_READ; p++) begin
                    compare_source(p, 1'b0);
                    compare_source(p, 1'b1);
                end
            end
        end
    end

    task automatic drive_random();
        logic           used [prf_pkg::N_PREG];
        logic [31:0]    r;
        prf_pkg::preg_t pick;
        foreach (used[i]) begin
            used[i] = 1'b0;
        end
        r  = $random(seed);
        we = (r[1:0] != 2'b00);
        // Half the picks land in the low 16 registers for more reuse
        for (int c = 0; c < prf_pkg::N_WB; c++) begin
            r    = $random(seed);
            pick = r[24] ? {2'b00, r[19:16]} : r[21:16];
            while (used[pick]) begin
                pick = pick + prf_pkg::preg_t'(1);
            end
            wb_valid[c]  = r[0];
            wb_rd[c]     = pick;
            wb_rob_id[c] = r[10:8];
            wb_value[c]  = $random(seed);
            used[pick]   = r[0];
        end
        for (int d = 0; d < prf_pkg::N_DISP; d++) begin
            r    = $random(seed);
            pick = r[24] ? {2'b00, r[19:16]} : r[21:16];
            while (used[pick]) begin
                pick = pick + prf_pkg::preg_t'(1);
            end
            disp_en[d]     = r[0];
            disp_rd[d]     = pick;
            disp_rob_id[d] = r[10:8];
            used[pick]     = r[0];
        end
        // Reads often aim at a writeback target to exercise forwarding
        for (int p = 0; p < prf_pkg::N_READ; p++) begin
            r      = $random(seed);
            rs1[p] = r[0] ? wb_rd[r[2:1] % prf_pkg::N_WB] : r[13:8];
            rs2[p] = r[3] ? wb_rd[r[5:4] % prf_pkg::N_WB] : r[21:16];
        end
    endtask

    initial begin
        rst = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Sweep all registers after reset
        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < prf_pkg::N_READ; p++) begin
                rs1[p] = prf_pkg::preg_t'(8 * k + p);
                rs2[p] = prf_pkg::preg_t'(8 * k + 4 + p);
            end
            @(negedge clk);
        end

        // Both dispatch ports in one cycle
        idle_inputs();
        disp_en[0] = 1'b1;
        disp_rd[0] = 6'd5;
        disp_rob_id[0] = 3'd3;
        disp_en[1] = 1'b1;
        disp_rd[1] = 6'd9;
        disp_rob_id[1] = 3'd6;
        rs1[0] = 6'd5;
        rs2[0] = 6'd9;
        rs1[1] = 6'd12;
        #10;
        expect_read(0, 1'b0, 32'h0, 1'b0, 3'd0);
        @(negedge clk);
        idle_inputs();
        #10;
        expect_read(0, 1'b0, 32'h0, 1'b1, 3'd3);
        expect_read(0, 1'b1, 32'h0, 1'b1, 3'd6);

        // One writeback per channel, forwarded in the same cycle
        @(negedge clk);
        wb_valid[0] = 1'b1;
        wb_rd[0] = 6'd5;
        wb_value[0] = 32'hdead_beef;
        wb_rob_id[0] = 3'd7;
        wb_valid[1] = 1'b1;
        wb_rd[1] = 6'd9;
        wb_value[1] = 32'h1234_5678;
        wb_rob_id[1] = 3'd1;
        wb_valid[2] = 1'b1;
        wb_rd[2] = 6'd12;
        wb_value[2] = 32'h0bad_f00d;
        wb_rob_id[2] = 3'd2;
        #10;
        expect_read(0, 1'b0, 32'hdead_beef, 1'b0, 3'd7);
        expect_read(0, 1'b1, 32'h1234_5678, 1'b0, 3'd1);
        expect_read(1, 1'b0, 32'h0bad_f00d, 1'b0, 3'd2);
        @(negedge clk);
        idle_inputs();
        #10;
        expect_read(0, 1'b0, 32'hdead_beef, 1'b0, 3'd3);
        expect_read(0, 1'b1, 32'h1234_5678, 1'b0, 3'd6);
        expect_read(1, 1'b0, 32'h0bad_f00d, 1'b0, 3'd0);

        // Stall: forwarding only, storage untouched
        @(negedge clk);
        we = 1'b0;
        disp_en[0] = 1'b1;
        disp_rd[0] = 6'd12;
        disp_rob_id[0] = 3'd4;
        wb_valid[1] = 1'b1;
        wb_rd[1] = 6'd5;
        wb_value[1] = 32'hcafe_0001;
        wb_rob_id[1] = 3'd5;
        #10;
        expect_read(0, 1'b0, 32'hcafe_0001, 1'b0, 3'd5);
        expect_read(1, 1'b0, 32'h0bad_f00d, 1'b0, 3'd0);
        @(negedge clk);
        idle_inputs();
        #10;
        expect_read(0, 1'b0, 32'hdead_beef, 1'b0, 3'd3);
        expect_read(1, 1'b0, 32'h0bad_f00d, 1'b0, 3'd0);

        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            drive_random();
        end
        @(negedge clk);
        idle_inputs();
        @(negedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tests
design/prf_pkg.sv
design/prf_storage.sv
design/cdb_bypass.sv
design/phys_reg_file.sv
tests/tb_phys_reg_file.sv
